// File: Bender.yml
package:
  name: rv_core

sources:
  - verilog/rv_pkg.sv
  - verilog/fetch_unit.sv
  - verilog/control_fsm.sv
  - verilog/exec_unit.sv
  - verilog/bus_arbiter.sv
  - verilog/rv_core.sv
  - target: test
    files:
      - verif/tb_checker.sv
      - verif/tb_top.sv

// File: all.f
verilog/rv_pkg.sv
verilog/fetch_unit.sv
verilog/control_fsm.sv
verilog/exec_unit.sv
verilog/bus_arbiter.sv
verilog/rv_core.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: verif/tb_checker.sv
`timescale 1ns/1ns

module tb_checker import rv_pkg::*; (
    input  logic          Clock,
    input  logic          Reset_L,
    input  mem_req_t      mem_req,
    input  mem_rsp_t      mem_rsp,
    input  logic          halted,
    input  xlen_t [255:0] image,
    input  logic          image_ready,
    input  logic          run_done,
    output int            mismatch_count,
    output int            other_count,
    output bit            check_done
);

    // expected bus transactions in order
    logic  exp_we [$];
    xlen_t exp_addr [$];
    xlen_t exp_data [$];
    int    ref_instrs;
    int    next_idx;
    int    cycles_out_of_reset;
    bit    first_seen;
    bit    halted_seen;

    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt, input xlen_t a,
                                      input xlen_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branch_ref(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // instruction-set model of the image, returns the executed instruction count
    function automatic int run_reference(input xlen_t [255:0] img);
        xlen_t      m [256];
        xlen_t      x [32];
        xlen_t      pc, w, a, b, addr, res, next_pc;
        xlen_t      imm_i, imm_s, imm_b, imm_j;
        logic [6:0] op;
        int         steps;
        bit         wr;
        for (int i = 0; i < 256; i++) begin
            m[i] = img[i];
        end
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        pc    = RESET_PC;
        steps = 0;
        while (steps < 1000) begin
            exp_we.push_back(1'b0);
            exp_addr.push_back(pc);
            exp_data.push_back('0);
            w  = m[pc[9:2]];
            op = w[6:0];
            if (op == OP_HALT) begin
                break;
            end
            steps++;
            a       = x[w[19:15]];
            b       = x[w[24:20]];
            imm_i   = {{20{w[31]}}, w[31:20]};
            imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            imm_j   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            next_pc = pc + 32'd4;
            wr      = 1'b1;
            res     = '0;
            case (op)
                OP_R: res = alu_ref(w[14:12], w[30], a, b);
                OP_I: res = alu_ref(w[14:12], (w[14:12] == 3'd5) && w[30], a, imm_i);
                OP_LUI: res = {w[31:12], 12'b0};
                OP_JAL: begin
                    res     = pc + 32'd4;
                    next_pc = pc + imm_j;
                end
                OP_LOAD: begin
                    addr = a + imm_i;
                    exp_we.push_back(1'b0);
                    exp_addr.push_back(addr);
                    exp_data.push_back('0);
                    res = m[addr[9:2]];
                end
                OP_STORE: begin
                    addr = a + imm_s;
                    exp_we.push_back(1'b1);
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    m[addr[9:2]] = b;
                    wr = 1'b0;
                end
                OP_BRANCH: begin
                    if (branch_ref(w[14:12], a, b)) begin
                        next_pc = pc + imm_b;
                    end
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 5'd0) begin
                x[w[11:7]] = res;
            end
            pc = next_pc;
        end
        return steps;
    endfunction

    initial begin
        wait (image_ready === 1'b1);
        ref_instrs = run_reference(image);
        $display("reference model: %0d instructions, %0d bus transactions", ref_instrs,
                 exp_addr.size());
    end

    task automatic compare_transaction();
        if (next_idx >= exp_addr.size()) begin
            other_count++;
            $display("error: extra %s transaction at address %h after the expected list ended",
                     mem_req.we ? "write" : "read", mem_req.addr);
        end else begin
            if (mem_req.we !== exp_we[next_idx]) begin
                mismatch_count++;
                $display("mismatch mem_req.we at transaction %0d: got %h expected %h",
                         next_idx, mem_req.we, exp_we[next_idx]);
            end
            if (mem_req.addr !== exp_addr[next_idx]) begin
                mismatch_count++;
                $display("mismatch mem_req.addr at transaction %0d: got %h expected %h",
                         next_idx, mem_req.addr, exp_addr[next_idx]);
            end
            if (exp_we[next_idx] && mem_req.wdata !== exp_data[next_idx]) begin
                mismatch_count++;
                $display("mismatch mem_req.wdata at transaction %0d: got %h expected %h",
                         next_idx, mem_req.wdata, exp_data[next_idx]);
            end
            next_idx++;
        end
    endtask

    // sampled mid-cycle, away from both the DUT and the memory edges
    always @(negedge Clock) begin
        if (!Reset_L) begin
            if (halted !== 1'b0 || mem_req.valid !== 1'b0) begin
                other_count++;
                $display("error: halted or a memory request is active during reset at %0t",
                         $time);
            end
        end else begin
            if (!first_seen) begin
                cycles_out_of_reset++;
                if (mem_req.valid === 1'b1) begin
                    first_seen = 1'b1;
                end else if (cycles_out_of_reset == 3) begin
                    other_count++;
                    $display("error: no fetch request within two cycles after reset release");
                end
            end
            if (halted_seen && halted !== 1'b1) begin
                other_count++;
                $display("error: halted dropped after it was raised at %0t", $time);
            end
            if (!halted_seen && halted === 1'b1) begin
                halted_seen = 1'b1;
                if (next_idx != exp_addr.size()) begin
                    other_count++;
                    $display("error: halted raised after %0d of %0d expected transactions",
                             next_idx, exp_addr.size());
                end
            end
            if (mem_req.valid === 1'b1 && mem_rsp.ack === 1'b1) begin
                compare_transaction();
            end
            if (run_done && !check_done) begin
                if (!halted_seen) begin
                    other_count++;
                    $display("error: halted was never raised");
                end
                if (next_idx < exp_addr.size()) begin
                    other_count++;
                    $display("error: missing transactions, only %0d of %0d were acknowledged",
                             next_idx, exp_addr.size());
                end
                check_done = 1'b1;
            end
        end
    end

endmodule

// File: verif/tb_top.sv
`timescale 1ns/1ns

module tb_top import rv_pkg::*; ();

    localparam int RESET_CYCLES     = 8;
    localparam int DRAIN_CYCLES     = 40;
    localparam int CYCLES_PER_INSTR = 12;

    logic     Clock = 1'b0;
    logic     Reset_L;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp = '0;
    logic     halted;

    xlen_t [255:0] image;
    xlen_t         mem [256];
    logic          image_ready = 1'b0;
    logic          run_done = 1'b0;
    bit            check_done;
    int            mismatch_count;
    int            other_count;
    int            prog_len;
    int            data_off;
    xlen_t         lcg_state = 32'd36517;
    bit            busy;
    int            ack_wait;

    always #2 Clock = ~Clock;

    rv_core DUT (
        .Clock   (Clock),
        .Reset_L (Reset_L),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp),
        .halted  (halted)
    );

    tb_checker chk (
        .Clock          (Clock),
        .Reset_L        (Reset_L),
        .mem_req        (mem_req),
        .mem_rsp        (mem_rsp),
        .halted         (halted),
        .image          (image),
        .image_ready    (image_ready),
        .run_done       (run_done),
        .mismatch_count (mismatch_count),
        .other_count    (other_count),
        .check_done     (check_done)
    );

    function automatic xlen_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // instruction encoders take immediates as plain integers
    function automatic xlen_t enc_r(input int f7, input int rs2, input int rs1, input int f3,
                                    input int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OP_R};
    endfunction

    function automatic xlen_t enc_i(input int imm, input int rs1, input int f3, input int rd,
                                    input logic [6:0] op);
        xlen_t v;
        v = xlen_t'(imm);
        return {v[11:0], 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic xlen_t enc_s(input int imm, input int rs2, input int rs1, input int f3);
        xlen_t v;
        v = xlen_t'(imm);
        return {v[11:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:0], OP_STORE};
    endfunction

    function automatic xlen_t enc_b(input int imm, input int rs2, input int rs1, input int f3);
        xlen_t v;
        v = xlen_t'(imm);
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], OP_BRANCH};
    endfunction

    function automatic xlen_t enc_j(input int imm, input int rd);
        xlen_t v;
        v = xlen_t'(imm);
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), OP_JAL};
    endfunction

    function automatic xlen_t enc_u(input int imm20, input int rd);
        xlen_t v;
        v = xlen_t'(imm20);
        return {v[19:0], 5'(rd), OP_LUI};
    endfunction

    task automatic emit(input xlen_t w);
        image[prog_len] = w;
        prog_len++;
    endtask

    // sw rs2 into the next word of the result area at x10
    task automatic store_reg(input int rs2);
        emit(enc_s(data_off, rs2, 10, 2));
        data_off += 4;
    endtask

    task automatic build_program();
        logic [3:0] r_ops [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hD, 4'h6, 4'h7};
        logic [2:0] i_f3 [9]   = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
        logic [2:0] br_f3 [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        // x20 = -5, x21 = x22 = 7; first pair is taken, second is not
        int         br_t1 [6]  = '{21, 20, 20, 21, 21, 20};
        int         br_t2 [6]  = '{22, 21, 21, 20, 20, 21};
        int         br_n1 [6]  = '{20, 21, 21, 20, 20, 21};
        int         br_n2 [6]  = '{21, 22, 20, 21, 21, 20};
        xlen_t      r;
        int         imm;
        int         ld_off;
        for (int i = 0; i < 256; i++) begin
            image[i] = 32'h5A5A_0000 ^ xlen_t'(i * 4);
        end
        prog_len = 0;
        data_off = 0;
        for (int k = 1; k <= 8; k++) begin
            r = lcg_next();
            emit(enc_i(int'(r[27:16]), 0, 0, k, OP_I));
        end
        emit(enc_i(512, 0, 0, 10, OP_I));
        emit(enc_i(-5, 0, 0, 20, OP_I));
        emit(enc_i(7, 0, 0, 21, OP_I));
        emit(enc_i(7, 0, 0, 22, OP_I));
        for (int k = 0; k < 10; k++) begin
            emit(enc_r(r_ops[k][3] ? 32 : 0, 1 + (k + 3) % 8, 1 + k % 8, int'(r_ops[k][2:0]), 11));
            store_reg(11);
        end
        // shifts take a 5-bit amount, srai also sets imm[10]
        for (int k = 0; k < 9; k++) begin
            r = lcg_next();
            imm = int'(r[27:16]);
            if (i_f3[k] == 3'd1 || i_f3[k] == 3'd5) begin
                imm = imm & 31;
            end
            if (k == 8) begin
                imm = imm | 32'h400;
            end
            emit(enc_i(imm, 1 + k % 8, int'(i_f3[k]), 12, OP_I));
            store_reg(12);
        end
        r = lcg_next();
        emit(enc_u(int'(r[31:12]), 9));
        store_reg(9);
        ld_off = data_off;
        store_reg(3);
        emit(enc_i(ld_off, 10, 2, 13, OP_LOAD));
        store_reg(13);
        // a taken branch skips the increment of x23
        for (int k = 0; k < 6; k++) begin
            emit(enc_b(8, br_t2[k], br_t1[k], int'(br_f3[k])));
            emit(enc_i(1, 23, 0, 23, OP_I));
            emit(enc_b(8, br_n2[k], br_n1[k], int'(br_f3[k])));
            emit(enc_i(1, 23, 0, 23, OP_I));
        end
        store_reg(23);
        emit(enc_j(8, 24));
        emit(enc_i(1, 25, 0, 25, OP_I));
        store_reg(24);
        store_reg(25);
        emit(32'h0000_0000);
    endtask

    // the memory answers one request at a time after 0 to 3 cycles
    always @(posedge Clock) begin
        #1;
        if (!Reset_L || mem_rsp.ack) begin
            mem_rsp = '0;
            busy    = 1'b0;
        end else if (mem_req.valid) begin
            if (!busy) begin
                busy     = 1'b1;
                ack_wait = int'(lcg_next() >> 30);
            end
            if (ack_wait == 0) begin
                if (mem_req.we) begin
                    mem[mem_req.addr[9:2]] = mem_req.wdata;
                    mem_rsp.rdata = '0;
                end else begin
                    mem_rsp.rdata = mem[mem_req.addr[9:2]];
                end
                mem_rsp.ack = 1'b1;
            end else begin
                ack_wait--;
            end
        end
    end

    initial begin
        Reset_L = 1'b0;
        build_program();
        for (int i = 0; i < 256; i++) begin
            mem[i] = image[i];
        end
        // the image settles before the checker reads it
        #1;
        image_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge Clock);
        #1;
        Reset_L = 1'b1;
        wait (halted === 1'b1);
        // keep the memory answering to catch any request after halt
        repeat (DRAIN_CYCLES) @(posedge Clock);
        #1;
        run_done = 1'b1;
        wait (check_done);
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (image_ready === 1'b1);
        #((prog_len * CYCLES_PER_INSTR + RESET_CYCLES + DRAIN_CYCLES) * 4);
        $display("timeout: the core did not halt and finish within %0d instruction slots",
                 prog_len);
        $display("errors: %0d mismatches, %0d other, 1 timeout", mismatch_count, other_count);
        $display("Test failed");
        $finish;
    end

endmodule

// File: verilog/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter import rv_pkg::*; (
    input  logic     Clock,
    input  logic     Reset_L,
    input  mem_req_t fetch_req,
    input  mem_req_t data_req,
    output mem_rsp_t fetch_rsp,
    output mem_rsp_t data_rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    logic granted;
    logic owner_data;

    // data wins when both ask in the same idle cycle
    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            granted    <= 1'b0;
            owner_data <= 1'b0;
        end else if (!granted) begin
            if (data_req.valid) begin
                granted    <= 1'b1;
                owner_data <= 1'b1;
            end else if (fetch_req.valid) begin
                granted    <= 1'b1;
                owner_data <= 1'b0;
            end
        end else if (mem_rsp.ack) begin
            granted <= 1'b0;
        end
    end

    always_comb begin
        mem_req   = '0;
        fetch_rsp = '0;
        data_rsp  = '0;
        if (granted) begin
            if (owner_data) begin
                mem_req  = data_req;
                data_rsp = mem_rsp;
            end else begin
                mem_req   = fetch_req;
                fetch_rsp = mem_rsp;
            end
        end
    end

endmodule

// File: verilog/control_fsm.sv
`timescale 1ns/1ns

module control_fsm import rv_pkg::*; (
    input  logic     Clock,
    input  logic     Reset_L,
    input  instr_u   instr,
    input  logic     instr_valid,
    input  xlen_t    alu_result,
    input  xlen_t    rs2_data,
    output mem_req_t data_req,
    input  mem_rsp_t data_rsp,
    output logic     fetch_go,
    output logic     pc_update,
    output logic     take_target,
    output logic     rd_we,
    output alu_op_t  alu_op,
    output logic     use_imm,
    output xlen_t    imm,
    output wb_sel_t  wb_sel,
    output logic     halted
);

    typedef enum logic [2:0] {
        S_FETCH, S_DECODE, S_EXEC, S_MEM_WAIT, S_WRITE_BACK, S_PC_UPDATE, S_HALT
    } state_t;

    state_t     state;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_load, is_store, is_branch, is_jal, is_lui, is_alu;
    logic       cond, taken;
    logic       mem_active, mem_we;
    xlen_t      imm_i, imm_s, imm_b, imm_j, imm_u;

    assign opcode    = instr.r.opcode;
    assign funct3    = instr.r.funct3;
    assign is_load   = (opcode == OP_LOAD);
    assign is_store  = (opcode == OP_STORE);
    assign is_branch = (opcode == OP_BRANCH);
    assign is_jal    = (opcode == OP_JAL);
    assign is_lui    = (opcode == OP_LUI);
    assign is_alu    = (opcode == OP_R) || (opcode == OP_I);

    assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
    assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                    instr.j.imm_11, instr.j.imm_10_1, 1'b0};
    assign imm_u = {instr.u.imm_31_12, 12'b0};

    // eq/ne test a zero difference, the rest the slt bit; funct3[0] inverts
    assign cond  = funct3[2] ? alu_result[0] : (alu_result == '0);
    assign taken = cond ^ funct3[0];

    assign data_req = '{valid: mem_active, we: mem_we, addr: alu_result, wdata: rs2_data};

    // datapath controls latched once per instruction
    always_ff @(posedge Clock) begin
        if (state == S_DECODE) begin
            use_imm <= !((opcode == OP_R) || is_branch);
            alu_op  <= ALU_ADD;
            wb_sel  <= WB_ALU;
            imm     <= imm_i;
            mem_we  <= is_store;
            case (opcode)
                OP_R: alu_op <= alu_op_t'({instr.r.funct7[5], funct3});
                // only srai takes the imm[10] bit as the op modifier
                OP_I: alu_op <= alu_op_t'({(funct3 == 3'b101) && instr.i.imm_11_0[10], funct3});
                OP_LOAD: wb_sel <= WB_LOAD;
                OP_STORE: imm <= imm_s;
                OP_BRANCH: begin
                    imm <= imm_b;
                    if (!funct3[2]) begin
                        alu_op <= ALU_SUB;
                    end else begin
                        alu_op <= funct3[1] ? ALU_SLTU : ALU_SLT;
                    end
                end
                OP_JAL: begin
                    imm    <= imm_j;
                    wb_sel <= WB_LINK;
                end
                OP_LUI: begin
                    imm    <= imm_u;
                    wb_sel <= WB_IMM;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            state       <= S_FETCH;
            fetch_go    <= 1'b0;
            pc_update   <= 1'b0;
            take_target <= 1'b0;
            rd_we       <= 1'b0;
            mem_active  <= 1'b0;
            halted      <= 1'b0;
        end else begin
            fetch_go  <= 1'b0;
            pc_update <= 1'b0;
            rd_we     <= 1'b0;
            case (state)
                S_FETCH: begin
                    if (instr_valid) begin
                        if (opcode == OP_HALT) begin
                            halted <= 1'b1;
                            state  <= S_HALT;
                        end else begin
                            state <= S_DECODE;
                        end
                    end
                end
                S_DECODE: begin
                    rd_we      <= is_alu || is_lui || is_jal;
                    mem_active <= is_load || is_store;
                    state      <= S_EXEC;
                end
                S_EXEC: begin
                    if (is_load || is_store) begin
                        state <= S_MEM_WAIT;
                    end else begin
                        pc_update   <= 1'b1;
                        take_target <= is_jal || (is_branch && taken);
                        state       <= S_PC_UPDATE;
                    end
                end
                S_MEM_WAIT: begin
                    if (data_rsp.ack) begin
                        mem_active  <= 1'b0;
                        rd_we       <= is_load;
                        pc_update   <= 1'b1;
                        take_target <= 1'b0;
                        state       <= S_WRITE_BACK;
                    end
                end
                S_WRITE_BACK, S_PC_UPDATE: begin
                    fetch_go <= 1'b1;
                    state    <= S_FETCH;
                end
                S_HALT: state <= S_HALT;
                default: state <= S_FETCH;
            endcase
        end
    end

endmodule

// File: verilog/exec_unit.sv
`timescale 1ns/1ns

module exec_unit import rv_pkg::*; (
    input  logic    Clock,
    input  logic    Reset_L,
    input  instr_u  instr,
    input  logic    rd_we,
    input  alu_op_t alu_op,
    input  logic    use_imm,
    input  xlen_t   imm,
    input  wb_sel_t wb_sel,
    input  xlen_t   load_data,
    input  xlen_t   link_addr,
    output xlen_t   alu_result,
    output xlen_t   rs2_data
);

    xlen_t    regs [32];
    reg_idx_t rs1, rs2, rd;
    xlen_t    rs1_data;
    xlen_t    op_b;
    xlen_t    load_q;
    xlen_t    wb_data;

    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;
    assign rd  = instr.r.rd;

    // x0 reads as zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];
    assign op_b     = use_imm ? imm : rs2_data;

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = rs1_data + op_b;
            ALU_SUB:  alu_result = rs1_data - op_b;
            ALU_SLL:  alu_result = rs1_data << op_b[4:0];
            ALU_SLT:  alu_result = {31'b0, $signed(rs1_data) < $signed(op_b)};
            ALU_SLTU: alu_result = {31'b0, rs1_data < op_b};
            ALU_XOR:  alu_result = rs1_data ^ op_b;
            ALU_SRL:  alu_result = rs1_data >> op_b[4:0];
            ALU_SRA:  alu_result = $signed(rs1_data) >>> op_b[4:0];
            ALU_OR:   alu_result = rs1_data | op_b;
            ALU_AND:  alu_result = rs1_data & op_b;
            default:  alu_result = '0;
        endcase
    end

    // load data captured in the ack cycle, written back one cycle later
    always_ff @(posedge Clock) begin
        load_q <= load_data;
    end

    always_comb begin
        case (wb_sel)
            WB_ALU:  wb_data = alu_result;
            WB_LOAD: wb_data = load_q;
            WB_LINK: wb_data = link_addr;
            WB_IMM:  wb_data = imm;
            default: wb_data = alu_result;
        endcase
    end

    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (rd_we && (rd != '0)) begin
            regs[rd] <= wb_data;
        end
    end

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit import rv_pkg::*; (
    input  logic     Clock,
    input  logic     Reset_L,
    input  logic     fetch_go,
    input  logic     pc_update,
    input  logic     take_target,
    input  xlen_t    imm,
    output mem_req_t fetch_req,
    input  mem_rsp_t fetch_rsp,
    output instr_u   instr,
    output logic     instr_valid,
    output xlen_t    link_addr
);

    xlen_t  pc;
    logic   fetch_active;
    instr_u ir;

    assign fetch_req = '{valid: fetch_active, we: 1'b0, addr: pc, wdata: '0};
    assign instr     = ir;
    assign link_addr = pc + INSTR_BYTES;

    // out of reset the unit is already asking for the word at RESET_PC
    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            pc           <= RESET_PC;
            fetch_active <= 1'b1;
            instr_valid  <= 1'b0;
        end else begin
            instr_valid <= fetch_rsp.ack;
            if (fetch_rsp.ack) begin
                fetch_active <= 1'b0;
            end else if (fetch_go) begin
                fetch_active <= 1'b1;
            end
            if (pc_update) begin
                pc <= take_target ? pc + imm : link_addr;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (fetch_rsp.ack) begin
            ir <= fetch_rsp.rdata;
        end
    end

endmodule

// File: verilog/rv_core.sv
`timescale 1ns/1ns

module rv_core import rv_pkg::*; (
    input  logic     Clock,
    input  logic     Reset_L,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp,
    output logic     halted
);

    mem_req_t fetch_req;
    mem_req_t data_req;
    mem_rsp_t fetch_rsp;
    mem_rsp_t data_rsp;
    instr_u   instr;
    logic     instr_valid;
    logic     fetch_go;
    logic     pc_update;
    logic     take_target;
    logic     rd_we;
    logic     use_imm;
    alu_op_t  alu_op;
    wb_sel_t  wb_sel;
    xlen_t    imm;
    xlen_t    link_addr;
    xlen_t    alu_result;
    xlen_t    rs2_data;

    fetch_unit u_fetch (
        .Clock       (Clock),
        .Reset_L     (Reset_L),
        .fetch_go    (fetch_go),
        .pc_update   (pc_update),
        .take_target (take_target),
        .imm         (imm),
        .fetch_req   (fetch_req),
        .fetch_rsp   (fetch_rsp),
        .instr       (instr),
        .instr_valid (instr_valid),
        .link_addr   (link_addr)
    );

    control_fsm u_ctrl (
        .Clock       (Clock),
        .Reset_L     (Reset_L),
        .instr       (instr),
        .instr_valid (instr_valid),
        .alu_result  (alu_result),
        .rs2_data    (rs2_data),
        .data_req    (data_req),
        .data_rsp    (data_rsp),
        .fetch_go    (fetch_go),
        .pc_update   (pc_update),
        .take_target (take_target),
        .rd_we       (rd_we),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .imm         (imm),
        .wb_sel      (wb_sel),
        .halted      (halted)
    );

    // load data comes straight from the data side of the arbiter
    exec_unit u_exec (
        .Clock      (Clock),
        .Reset_L    (Reset_L),
        .instr      (instr),
        .rd_we      (rd_we),
        .alu_op     (alu_op),
        .use_imm    (use_imm),
        .imm        (imm),
        .wb_sel     (wb_sel),
        .load_data  (data_rsp.rdata),
        .link_addr  (link_addr),
        .alu_result (alu_result),
        .rs2_data   (rs2_data)
    );

    bus_arbiter u_arb (
        .Clock     (Clock),
        .Reset_L   (Reset_L),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .fetch_rsp (fetch_rsp),
        .data_rsp  (data_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

endmodule

// File: verilog/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one instruction word, read through each format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        j_fmt_t j;
        u_fmt_t u;
    } instr_u;

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_HALT   = 7'b0000000;

    // encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1,
        WB_LINK = 2'd2,
        WB_IMM  = 2'd3
    } wb_sel_t;

    typedef struct packed {
        logic  valid;
        logic  we;
        xlen_t addr;
        xlen_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ack;
        xlen_t rdata;
    } mem_rsp_t;

    localparam xlen_t INSTR_BYTES = 32'd4;
    localparam xlen_t RESET_PC    = 32'h0000_0000;

endpackage
